//--- Bender.yml
package:
  name: tiny16

sources:
  - tiny16_pkg.sv
  - tiny16_decode.sv
  - tiny16_alu.sv
  - tiny16_core.sv
  - tiny16_ram.sv
  - tiny16_system.sv
  - target: test
    files:
      - tb_tiny16.sv

//--- files.f
tiny16_pkg.sv
tiny16_decode.sv
tiny16_alu.sv
tiny16_core.sv
tiny16_ram.sv
tiny16_system.sv
tb_tiny16.sv

//--- tb_tiny16.sv
`timescale 1ns/1ns

module tb_tiny16;
    import tiny16_pkg::*;

    localparam int margin = 16;
    // executed instructions of the halt, alu, memory, flow and interrupt tests
    localparam int instr_total = 1 + 60 + 13 + 16 + 8;
    // loading and readback cycles per test
    localparam int overhead = 600;
    localparam int global_limit = 5 * overhead + 4 * instr_total + 5 * margin;

    logic      clk;
    logic      reset;
    logic      interrupt;
    logic      hlt;
    logic      wfi;
    logic      in_interrupt;
    logic      load_we;
    ram_addr_t load_addr;
    word_t     load_wdata;
    word_t     load_rdata;

    word_t       image [ram_depth];
    int          pc_w;
    int          cycle_count;
    logic [31:0] rng_state;
    ram_addr_t   exp_addr [$];
    word_t       exp_data [$];

    tiny16_system u_dut (
        .clk          (clk),
        .reset        (reset),
        .interrupt    (interrupt),
        .hlt          (hlt),
        .wfi          (wfi),
        .in_interrupt (in_interrupt),
        .load_we      (load_we),
        .load_addr    (load_addr),
        .load_wdata   (load_wdata),
        .load_rdata   (load_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > global_limit) begin
            fail_run("simulation ran past its cycle limit");
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch %s: expected %h, got %h", name, expected, actual));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // background pattern distinct for every word
    function automatic word_t fill_word(input int a);
        return {a[7:0] ^ 8'h3c, ~a[7:0]};
    endfunction

    // operand byte in 15..8 with the opcode in 7..4 and fields in 3..0
    function automatic word_t enc(input logic [3:0] major, input reg_idx_t d, input reg_idx_t s,
                                  input logic [7:0] hi);
        return {hi, major, d, s};
    endfunction

    function automatic word_t enc_jmp(input logic [11:0] off);
        return {off[7:0], 4'h0, off[11:8]};
    endfunction

    function automatic word_t enc_br(input logic [3:0] cond, input logic [7:0] off);
        return {off, 4'h1, cond};
    endfunction

    function automatic word_t enc_mvh(input reg_idx_t d, input logic [9:0] v);
        return enc(4'h2, d, v[9:8], v[7:0]);
    endfunction

    function automatic word_t enc_adi(input reg_idx_t d, input logic [9:0] v);
        return enc(4'h3, d, v[9:8], v[7:0]);
    endfunction

    function automatic word_t enc_store(input reg_idx_t base, input reg_idx_t src,
                                        input logic [7:0] off);
        return enc(4'h4, base, src, off);
    endfunction

    function automatic word_t enc_load(input reg_idx_t d, input reg_idx_t base,
                                       input logic [7:0] off);
        return enc(4'h5, d, base, off);
    endfunction

    function automatic word_t enc_sub(input logic [7:0] sub, input reg_idx_t d, input reg_idx_t s);
        return enc(4'h6, d, s, sub);
    endfunction

    function automatic word_t enc_loadpc(input reg_idx_t base, input logic [7:0] off);
        return enc(4'h7, 2'd0, base, off);
    endfunction

    function automatic word_t enc_call(input reg_idx_t sp, input logic [9:0] off);
        return enc(4'h8, sp, off[9:8], off[7:0]);
    endfunction

    // expected {carry, result} for an ALU sub-operation
    function automatic logic [16:0] alu_expect(input logic [7:0] sub, input word_t a,
                                               input word_t b, input logic cin);
        logic [16:0] r;
        case (sub)
            8'h03: r = {a[0], 1'b0, a[15:1]};
            8'h04: r = {a[15], a[14:0], 1'b0};
            8'h05: r = {cin, ~a};
            8'h06: r = {cin, 16'h0000 - a};
            8'h08: r = {1'b0, a} + {1'b0, b};
            8'h09: r = {1'b0, a} + {1'b0, b} + cin;
            8'h0a: r = {1'b0, a} - {1'b0, b};
            8'h0b: r = {1'b0, a} - {1'b0, b} - cin;
            8'h0c: r = {cin, a & b};
            8'h0d: r = {cin, a | b};
            default: r = {cin, a ^ b};
        endcase
        return r;
    endfunction

    task automatic clear_image();
        for (int i = 0; i < ram_depth; i++) begin
            image[i] = fill_word(i);
        end
        pc_w = 0;
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic emit(input word_t w);
        image[pc_w] = w;
        pc_w++;
    endtask

    // mvh then adi builds any 16-bit value
    task automatic emit_value(input reg_idx_t r, input word_t v);
        emit(enc_mvh(r, v[15:6]));
        emit(enc_adi(r, {4'b0000, v[5:0]}));
    endtask

    task automatic expect_word(input word_t a, input word_t v);
        exp_addr.push_back(a[7:0]);
        exp_data.push_back(v);
    endtask

    task automatic start_program();
        @(posedge clk);
        reset     <= 1'b0;
        interrupt <= 1'b0;
        for (int i = 0; i < ram_depth; i++) begin
            @(posedge clk);
            load_we    <= 1'b1;
            load_addr  <= i[7:0];
            load_wdata <= image[i];
        end
        @(posedge clk);
        load_we <= 1'b0;
        @(negedge clk);
        check_value("hlt", 16'(0), 16'(hlt));
        check_value("wfi", 16'(0), 16'(wfi));
        check_value("in_interrupt", 16'(0), 16'(in_interrupt));
        @(posedge clk);
        reset <= 1'b1;
    endtask

    // which picks hlt (0), wfi (1) or in_interrupt (2)
    task automatic wait_flag(input int which, input int limit, input string what);
        int   count;
        logic v;
        count = 0;
        v = 1'b0;
        while (!v) begin
            @(negedge clk);
            count++;
            case (which)
                0: v = hlt;
                1: v = wfi;
                default: v = in_interrupt;
            endcase
            if (!v && count >= limit) begin
                fail_run($sformatf("%s did not rise within %0d cycles", what, limit));
            end
        end
    endtask

    task automatic read_word(input ram_addr_t a, output word_t v);
        @(posedge clk);
        load_addr <= a;
        @(negedge clk);
        v = load_rdata;
    endtask

    task automatic check_expected();
        word_t v;
        foreach (exp_addr[i]) begin
            read_word(exp_addr[i], v);
            check_value($sformatf("mem[%02h]", exp_addr[i]), exp_data[i], v);
        end
    endtask

    task automatic test_halt();
        word_t v;
        clear_image();
        emit(enc_sub(8'h00, reg_a, reg_a));
        start_program();
        wait_flag(0, 8, "hlt");
        for (int i = 0; i < ram_depth; i++) begin
            read_word(i[7:0], v);
            check_value($sformatf("mem[%02h]", i), image[i], v);
        end
    endtask

    task automatic test_alu();
        logic [7:0]  subs [11] = '{8'h08, 8'h09, 8'h0a, 8'h0b, 8'h0c, 8'h0d, 8'h0e,
                                   8'h05, 8'h06, 8'h04, 8'h03};
        logic [16:0] r;
        word_t       wv;
        word_t       xv;
        logic        c;
        logic [7:0]  addr;
        clear_image();
        rng_state = xorshift32(rng_state);
        wv = rng_state[15:0];
        rng_state = xorshift32(rng_state);
        xv = rng_state[31:16];
        emit_value(reg_w, wv);
        emit_value(reg_x, xv);
        c = 1'b0;
        addr = 8'h40;
        foreach (subs[i]) begin
            if (subs[i] == 8'h09 || subs[i] == 8'h0b) begin
                // shl of 0xffc0 sets carry
                emit(enc_mvh(reg_sp, 10'h3ff));
                emit(enc_sub(8'h04, reg_sp, reg_sp));
                r = alu_expect(8'h04, 16'hffc0, 16'h0000, c);
                c = r[16];
            end
            emit(enc_sub(8'h07, reg_a, reg_w));
            emit(enc_sub(subs[i], reg_a, reg_x));
            r = alu_expect(subs[i], wv, xv, c);
            c = r[16];
            emit(enc_store(reg_a, reg_a, addr));
            expect_word({8'h00, addr}, r[15:0]);
            addr++;
            if (subs[i] inside {8'h03, 8'h04, 8'h08, 8'h09, 8'h0a, 8'h0b}) begin
                emit(enc_mvh(reg_sp, 10'h000));
                emit(enc_sub(8'h09, reg_sp, reg_sp));
                r = alu_expect(8'h09, 16'h0000, 16'h0000, c);
                c = r[16];
                emit(enc_store(reg_a, reg_sp, addr));
                expect_word({8'h00, addr}, r[15:0]);
                addr++;
            end
        end
        emit(enc_sub(8'h00, reg_a, reg_a));
        start_program();
        wait_flag(0, 4 * pc_w + margin, "hlt");
        check_expected();
    endtask

    task automatic test_memory();
        word_t d1;
        word_t d2;
        word_t base_w;
        clear_image();
        rng_state = xorshift32(rng_state);
        d1 = rng_state[15:0];
        d2 = rng_state[31:16];
        base_w = 16'h0050;
        emit(enc_mvh(reg_w, 10'h001));
        emit(enc_adi(reg_w, 10'h010));
        emit_value(reg_x, d1);
        emit(enc_store(reg_a, reg_x, 8'h60));
        emit(enc_store(reg_w, reg_x, 8'h05));
        emit(enc_load(reg_a, reg_w, 8'h20));
        emit(enc_store(reg_a, reg_a, 8'h61));
        emit(enc_load(reg_sp, reg_a, 8'h70));
        emit(enc_sub(8'h07, reg_x, reg_sp));
        emit(enc_store(reg_a, reg_x, 8'h62));
        emit(enc_store(reg_w, reg_a, 8'hfe));
        emit(enc_sub(8'h00, reg_a, reg_a));
        image[8'h70] = d2;
        expect_word(16'h0060, d1);
        expect_word(base_w + 16'h0005, d1);
        expect_word(16'h0061, d2);
        expect_word(16'h0062, d2);
        expect_word(base_w + 16'hfffe, d2);
        start_program();
        wait_flag(0, 4 * pc_w + margin, "hlt");
        check_expected();
    endtask

    task automatic test_flow();
        word_t marker;
        clear_image();
        marker = 16'h0440;
        emit(enc_mvh(reg_w, 10'h011));
        emit(enc_mvh(reg_sp, 10'h002));
        emit(enc_jmp(12'd2));
        emit(enc_store(reg_a, reg_w, 8'h60));
        emit(enc_mvh(reg_x, 10'h000));
        emit(enc_sub(8'h08, reg_x, reg_x));
        // z is set so this branch is taken
        emit(enc_br(4'b0010, 8'd2));
        emit(enc_store(reg_a, reg_w, 8'h61));
        emit(enc_br(4'b0100, 8'd2));
        emit(enc_store(reg_a, reg_w, 8'h62));
        emit(enc_call(reg_sp, 10'd5));
        emit(enc_store(reg_a, reg_w, 8'h63));
        emit(enc_adi(reg_x, 10'd20));
        emit(enc_sub(8'h0f, reg_sp, reg_x));
        emit(enc_sub(8'h00, reg_a, reg_a));
        emit(enc_store(reg_a, reg_w, 8'h64));
        // return through the pushed word
        emit(enc_loadpc(reg_sp, 8'hff));
        emit(nop_instr);
        emit(nop_instr);
        emit(nop_instr);
        emit(enc_store(reg_a, reg_w, 8'h66));
        emit(enc_sub(8'h00, reg_a, reg_a));
        expect_word(16'h0060, fill_word(8'h60));
        expect_word(16'h0061, fill_word(8'h61));
        expect_word(16'h0062, marker);
        expect_word(16'h0063, marker);
        expect_word(16'h0064, marker);
        expect_word(16'h0066, marker);
        expect_word(16'h0080 - 16'h0001, 16'd14);
        start_program();
        wait_flag(0, 4 * 16 + margin, "hlt");
        check_expected();
    endtask

    task automatic test_interrupt();
        clear_image();
        emit(enc_jmp(12'd8));
        emit(enc_mvh(reg_x, 10'h022));
        emit(enc_store(reg_a, reg_x, 8'h60));
        emit(enc_sub(8'h02, reg_a, reg_a));
        emit(nop_instr);
        emit(nop_instr);
        emit(nop_instr);
        emit(nop_instr);
        emit(enc_mvh(reg_w, 10'h033));
        emit(enc_sub(8'h01, reg_a, reg_a));
        emit(enc_store(reg_a, reg_w, 8'h61));
        emit(enc_sub(8'h00, reg_a, reg_a));
        expect_word(16'h0060, 16'h0880);
        expect_word(16'h0061, 16'h0cc0);
        start_program();
        wait_flag(1, 4 * 3 + margin, "wfi");
        @(posedge clk);
        interrupt <= 1'b1;
        wait_flag(2, 8, "in_interrupt");
        check_value("wfi", 16'(0), 16'(wfi));
        @(posedge clk);
        interrupt <= 1'b0;
        wait_flag(0, 4 * 8 + margin, "hlt");
        check_value("in_interrupt", 16'(0), 16'(in_interrupt));
        check_expected();
    endtask

    initial begin
        reset       = 1'b0;
        interrupt   = 1'b0;
        load_we     = 1'b0;
        load_addr   = '0;
        load_wdata  = '0;
        cycle_count = 0;
        rng_state   = 32'haa21215b;
        repeat (5) @(posedge clk);
        test_halt();
        test_alu();
        test_memory();
        test_flow();
        test_interrupt();
        $display("all tests passed");
        $finish;
    end

endmodule

//--- tiny16_alu.sv
`timescale 1ns/1ns

module tiny16_alu (
    input  tiny16_pkg::op_t   op,
    input  tiny16_pkg::word_t a,
    input  tiny16_pkg::word_t b,
    input  tiny16_pkg::word_t imm10,
    input  logic              carry_in,
    output tiny16_pkg::word_t result,
    output logic              carry_out,
    output logic              carry_we
);
    import tiny16_pkg::*;

    always_comb begin
        result    = '0;
        carry_out = carry_in;
        carry_we  = 1'b0;
        case (op)
            op_adi: begin
                {carry_out, result} = {1'b0, a} + {1'b0, imm10};
                carry_we = 1'b1;
            end
            op_add: begin
                {carry_out, result} = {1'b0, a} + {1'b0, b};
                carry_we = 1'b1;
            end
            op_adc: begin
                {carry_out, result} = {1'b0, a} + {1'b0, b} + {16'h0000, carry_in};
                carry_we = 1'b1;
            end
            // carry holds the borrow out of the 17-bit difference
            op_sub: begin
                {carry_out, result} = {1'b0, a} - {1'b0, b};
                carry_we = 1'b1;
            end
            op_sbc: begin
                {carry_out, result} = {1'b0, a} - {1'b0, b} - {16'h0000, carry_in};
                carry_we = 1'b1;
            end
            op_shl: begin
                {carry_out, result} = {a, 1'b0};
                carry_we = 1'b1;
            end
            op_shr: begin
                {result, carry_out} = {1'b0, a};
                carry_we = 1'b1;
            end
            op_and: result = a & b;
            op_or:  result = a | b;
            op_xor: result = a ^ b;
            op_not: result = ~a;
            op_neg: result = -a;
            default: result = '0;
        endcase
    end

    // alu operations never leave unknown bits in the result
    always_comb begin
        if (is_alu_op(op)) begin
            result_known: assert final (!$isunknown(result))
                else $error("alu result has unknown bits for op %s", op.name());
        end
    end

endmodule

//--- tiny16_core.sv
`timescale 1ns/1ns

module tiny16_core (
    input  logic              clk,
    input  logic              reset,
    output tiny16_pkg::word_t address,
    input  tiny16_pkg::word_t data_in,
    output tiny16_pkg::word_t data_out,
    output logic              rd_n,
    output logic              wr_n,
    input  logic              interrupt,
    output logic              hlt,
    output logic              wfi,
    output logic              in_interrupt
);
    import tiny16_pkg::*;

    stage_t   stage;
    word_t    pc;
    word_t    saved_pc;
    word_t    instr;
    word_t    regs [4];
    word_t    acc;
    logic     c;
    logic     z;
    logic     n;

    op_t      op;
    reg_idx_t dest_reg;
    reg_idx_t source_reg;
    word_t    imm8;
    word_t    imm10;
    word_t    mvh_value;
    word_t    pc_step;

    word_t    alu_result;
    logic     alu_carry;
    logic     alu_carry_we;

    logic     is_load;
    logic     is_store;
    logic     take_irq;
    word_t    load_base;
    word_t    store_base;

    assign z = (acc == '0);
    assign n = acc[15];

    tiny16_decode u_decode (
        .instr      (instr),
        .c          (c),
        .z          (z),
        .n          (n),
        .op         (op),
        .dest_reg   (dest_reg),
        .source_reg (source_reg),
        .imm8       (imm8),
        .imm10      (imm10),
        .mvh_value  (mvh_value),
        .pc_step    (pc_step)
    );

    tiny16_alu u_alu (
        .op        (op),
        .a         (regs[dest_reg]),
        .b         (regs[source_reg]),
        .imm10     (imm10),
        .carry_in  (c),
        .result    (alu_result),
        .carry_out (alu_carry),
        .carry_we  (alu_carry_we)
    );

    assign is_load  = (op == op_load_mem) || (op == op_loadpc);
    assign is_store = (op == op_store_mem) || (op == op_call) || (op == op_call_reg);
    assign take_irq = interrupt && !in_interrupt;

    // register index 0 as a base means absolute
    assign load_base  = (source_reg == reg_a) ? '0 : regs[source_reg];
    assign store_base = (dest_reg == reg_a) ? '0 : regs[dest_reg];

    // instruction fetch in st_fetch and data access in st_wb
    assign rd_n = hlt || !((stage == st_fetch) || (is_load && stage == st_wb));
    assign wr_n = hlt || !(is_store && stage == st_wb);

    always_ff @(posedge clk) begin
        if (!reset) begin
            stage        <= st_addr;
            pc           <= '0;
            instr        <= nop_instr;
            address      <= '0;
            acc          <= '0;
            c            <= 1'b0;
            hlt          <= 1'b0;
            wfi          <= 1'b0;
            in_interrupt <= 1'b0;
        end else if (!hlt) begin
            case (stage)
                st_addr: begin
                    if (take_irq) begin
                        saved_pc     <= pc;
                        pc           <= irq_vector;
                        address      <= irq_vector;
                        in_interrupt <= 1'b1;
                        wfi          <= 1'b0;
                        stage        <= st_fetch;
                    end else if (op == op_wfi) begin
                        // park here until an interrupt is taken
                        wfi     <= 1'b1;
                        address <= pc;
                    end else begin
                        wfi     <= 1'b0;
                        address <= pc;
                        stage   <= st_fetch;
                    end
                end
                st_fetch: begin
                    instr <= data_in;
                    stage <= st_exec;
                end
                st_exec: begin
                    hlt <= (op == op_halt);
                    if (op == op_reti) begin
                        pc           <= saved_pc;
                        in_interrupt <= 1'b0;
                    end else if (op == op_call_reg) begin
                        pc <= regs[source_reg];
                    end else begin
                        pc <= pc + pc_step;
                    end
                    if (is_load) begin
                        address <= load_base + imm8;
                    end else if (op == op_call || op == op_call_reg) begin
                        // push return address below sp and leave sp untouched
                        address  <= regs[dest_reg] - 16'd1;
                        data_out <= pc + 16'd1;
                    end else if (op == op_store_mem) begin
                        address  <= store_base + imm8;
                        data_out <= regs[source_reg];
                    end
                    if (is_alu_op(op)) begin
                        acc <= alu_result;
                        if (alu_carry_we) begin
                            c <= alu_carry;
                        end
                    end
                    stage <= st_wb;
                end
                st_wb: begin
                    case (op)
                        op_loadpc:   pc <= data_in;
                        op_load_mem: regs[dest_reg] <= data_in;
                        op_mov:      regs[dest_reg] <= regs[source_reg];
                        op_mvh:      regs[dest_reg] <= mvh_value;
                        default: begin
                            if (is_alu_op(op)) begin
                                regs[dest_reg] <= acc;
                            end
                        end
                    endcase
                    stage <= st_addr;
                end
                default: stage <= st_addr;
            endcase
        end
    end

    stage_onehot: assert property (@(posedge clk) disable iff (!reset) $onehot(stage))
        else $error("stage is not one-hot");

    strobes_exclusive: assert property (@(posedge clk) disable iff (!reset) !(!rd_n && !wr_n))
        else $error("rd_n and wr_n low together");

    write_in_wb: assert property (@(posedge clk) disable iff (!reset) !wr_n |-> stage == st_wb)
        else $error("write strobe outside writeback");

endmodule

//--- tiny16_decode.sv
`timescale 1ns/1ns

module tiny16_decode (
    input  tiny16_pkg::word_t    instr,
    input  logic                 c,
    input  logic                 z,
    input  logic                 n,
    output tiny16_pkg::op_t      op,
    output tiny16_pkg::reg_idx_t dest_reg,
    output tiny16_pkg::reg_idx_t source_reg,
    output tiny16_pkg::word_t    imm8,
    output tiny16_pkg::word_t    imm10,
    output tiny16_pkg::word_t    mvh_value,
    output tiny16_pkg::word_t    pc_step
);
    import tiny16_pkg::*;

    logic [9:0]  value10;
    logic [11:0] value12;
    word_t       imm12;
    logic [2:0]  cond_hits;
    logic        cond_pass;

    // operands share the high byte and extend into the low nibble
    assign value10 = {instr[1:0], instr[15:8]};
    assign value12 = {instr[3:0], instr[15:8]};

    assign dest_reg   = instr[3:2];
    assign source_reg = instr[1:0];

    assign imm8      = {{8{instr[15]}}, instr[15:8]};
    assign imm10     = {{6{value10[9]}}, value10};
    assign imm12     = {{4{value12[11]}}, value12};
    assign mvh_value = {value10, 6'h00};

    // mask selects among the flags and bit 3 inverts
    assign cond_hits = instr[2:0] & {c, z, n};
    assign cond_pass = (|cond_hits) ^ instr[3];

    always_comb begin
        op = op_nop;
        case (instr[7:4])
            4'h0: op = op_jmp;
            4'h1: op = op_br;
            4'h2: op = op_mvh;
            4'h3: op = op_adi;
            4'h4: op = op_store_mem;
            4'h5: op = op_load_mem;
            4'h6: begin
                // sub-operation sits in the high byte
                case (instr[15:8])
                    8'h00: op = op_halt;
                    8'h01: op = op_wfi;
                    8'h02: op = op_reti;
                    8'h03: op = op_shr;
                    8'h04: op = op_shl;
                    8'h05: op = op_not;
                    8'h06: op = op_neg;
                    8'h07: op = op_mov;
                    8'h08: op = op_add;
                    8'h09: op = op_adc;
                    8'h0a: op = op_sub;
                    8'h0b: op = op_sbc;
                    8'h0c: op = op_and;
                    8'h0d: op = op_or;
                    8'h0e: op = op_xor;
                    8'h0f: op = op_call_reg;
                    default: op = op_nop;
                endcase
            end
            4'h7: op = op_loadpc;
            4'h8: op = op_call;
            default: op = op_nop;
        endcase
    end

    always_comb begin
        pc_step = 16'd1;
        if (op == op_jmp) begin
            pc_step = imm12;
        end else if (op == op_call) begin
            pc_step = imm10;
        end else if (op == op_br && cond_pass) begin
            pc_step = imm8;
        end
    end

endmodule

//--- tiny16_pkg.sv
package tiny16_pkg;

    typedef logic [15:0] word_t;
    typedef logic [1:0]  reg_idx_t;
    typedef logic [7:0]  ram_addr_t;

    localparam int ram_depth = 256;

    // all ones decodes as major opcode 15 and does nothing
    localparam word_t nop_instr  = 16'hffff;
    localparam word_t irq_vector = 16'h0001;

    localparam reg_idx_t reg_a  = 2'd0;
    localparam reg_idx_t reg_w  = 2'd1;
    localparam reg_idx_t reg_x  = 2'd2;
    localparam reg_idx_t reg_sp = 2'd3;

    typedef enum logic [4:0] {
        op_nop,
        op_jmp,
        op_br,
        op_mvh,
        op_adi,
        op_store_mem,
        op_load_mem,
        op_halt,
        op_wfi,
        op_reti,
        op_shr,
        op_shl,
        op_not,
        op_neg,
        op_mov,
        op_add,
        op_adc,
        op_sub,
        op_sbc,
        op_and,
        op_or,
        op_xor,
        op_call_reg,
        op_loadpc,
        op_call
    } op_t;

    // one-hot sequencer
    typedef enum logic [3:0] {
        st_addr  = 4'b0001,
        st_fetch = 4'b0010,
        st_exec  = 4'b0100,
        st_wb    = 4'b1000
    } stage_t;

    // operations whose result goes through acc
    function automatic logic is_alu_op(op_t op);
        return op inside {op_adi, op_shr, op_shl, op_not, op_neg, op_add, op_adc,
                          op_sub, op_sbc, op_and, op_or, op_xor};
    endfunction

endpackage

//--- tiny16_ram.sv
`timescale 1ns/1ns

module tiny16_ram (
    input  logic                  clk,
    input  tiny16_pkg::word_t     address,
    output tiny16_pkg::word_t     data_out,
    input  tiny16_pkg::word_t     data_in,
    input  logic                  wr_n,
    input  logic                  load_we,
    input  tiny16_pkg::ram_addr_t load_addr,
    input  tiny16_pkg::word_t     load_wdata,
    output tiny16_pkg::word_t     load_rdata
);
    import tiny16_pkg::*;

    word_t     mem [ram_depth];
    ram_addr_t core_addr;

    // addresses wrap modulo the array size
    assign core_addr = address[7:0];

    assign data_out   = mem[core_addr];
    assign load_rdata = mem[load_addr];

    // loader wins over the core
    always_ff @(posedge clk) begin
        if (load_we) begin
            mem[load_addr] <= load_wdata;
        end else if (!wr_n) begin
            mem[core_addr] <= data_in;
        end
    end

    no_write_clash: assert property (@(posedge clk)
        !(load_we && !wr_n && load_addr == core_addr))
        else $error("loader and core write word %0d together", load_addr);

endmodule

//--- tiny16_system.sv
`timescale 1ns/1ns

module tiny16_system (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  interrupt,
    output logic                  hlt,
    output logic                  wfi,
    output logic                  in_interrupt,
    input  logic                  load_we,
    input  tiny16_pkg::ram_addr_t load_addr,
    input  tiny16_pkg::word_t     load_wdata,
    output tiny16_pkg::word_t     load_rdata
);
    import tiny16_pkg::*;

    word_t address;
    word_t core_wdata;
    word_t core_rdata;
    logic  rd_n;
    logic  wr_n;

    tiny16_core u_core (
        .clk          (clk),
        .reset        (reset),
        .address      (address),
        .data_in      (core_rdata),
        .data_out     (core_wdata),
        .rd_n         (rd_n),
        .wr_n         (wr_n),
        .interrupt    (interrupt),
        .hlt          (hlt),
        .wfi          (wfi),
        .in_interrupt (in_interrupt)
    );

    tiny16_ram u_ram (
        .clk        (clk),
        .address    (address),
        .data_out   (core_rdata),
        .data_in    (core_wdata),
        .wr_n       (wr_n),
        .load_we    (load_we),
        .load_addr  (load_addr),
        .load_wdata (load_wdata),
        .load_rdata (load_rdata)
    );

endmodule
